// ==== hw/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

   // Instruction word layout
   localparam int OPC_W   = 4;
   localparam int OPC_MSB = 31;
   localparam int DR_LSB  = 24;
   localparam int SR1_LSB = 20;
   localparam int SR2_LSB = 16;
   localparam int IMM_W   = 16;

   typedef enum logic [OPC_W-1:0] {
      OP_NOP  = 4'h0,
      OP_ADD  = 4'h1,
      OP_SUB  = 4'h2,
      OP_AND  = 4'h3,
      OP_OR   = 4'h4,
      OP_XOR  = 4'h5,
      OP_ADDI = 4'h6,
      OP_MOVI = 4'h7,
      OP_HLT  = 4'hf
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD   = 3'd0,
      ALU_SUB   = 3'd1,
      ALU_AND   = 3'd2,
      ALU_OR    = 3'd3,
      ALU_XOR   = 3'd4,
      ALU_PASSB = 3'd5
   } aluk_t;

   // EFLAGS bit positions, x86 layout
   localparam int FLAG_CF = 0;
   localparam int FLAG_ZF = 6;
   localparam int FLAG_SF = 7;
   localparam int FLAG_OF = 11;

endpackage

`default_nettype wire

// ==== hw/pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

   // Data path width
   localparam int WORD_W = 32;

   typedef logic [WORD_W-1:0] word_t;

   // Register numbering
   localparam int REG_ID_W = 3;
   localparam int NUM_GPR  = 1 << REG_ID_W;

   typedef logic [REG_ID_W-1:0] reg_id_t;

   // Edges from the sampling edge to retirement:
   // input register, decode, operand read, execute, writeback
   localparam int PIPE_LATENCY = 4;

endpackage

`default_nettype wire

// ==== hw/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage import isa_pkg::*, pipe_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    instr_valid,
   input  word_t   instr,
   output logic    d_valid,
   output aluk_t   d_aluk,
   output logic    d_wr,
   output logic    d_halt,
   output logic    d_use_imm,
   output reg_id_t d_dr,
   output reg_id_t d_sr1,
   output reg_id_t d_sr2,
   output word_t   d_imm
);

   logic    in_valid;
   word_t   in_instr;
   opcode_t opc;
   aluk_t   aluk;
   logic    wr;
   logic    halt;
   logic    use_imm;

   // Sampling edge of the pipeline
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         in_valid <= 1'b0;
      end else begin
         in_valid <= instr_valid;
      end
   end

   always_ff @(posedge clk) begin
      in_instr <= instr;
   end

   assign opc = opcode_t'(in_instr[OPC_MSB -: OPC_W]);

   // Opcode to control bits, NOP and unknown codes do nothing
   always_comb begin
      aluk    = ALU_ADD;
      wr      = 1'b0;
      halt    = 1'b0;
      use_imm = 1'b0;
      case (opc)
         OP_ADD: wr = 1'b1;
         OP_SUB: begin
            aluk = ALU_SUB;
            wr   = 1'b1;
         end
         OP_AND: begin
            aluk = ALU_AND;
            wr   = 1'b1;
         end
         OP_OR: begin
            aluk = ALU_OR;
            wr   = 1'b1;
         end
         OP_XOR: begin
            aluk = ALU_XOR;
            wr   = 1'b1;
         end
         OP_ADDI: begin
            wr      = 1'b1;
            use_imm = 1'b1;
         end
         OP_MOVI: begin
            aluk    = ALU_PASSB;
            wr      = 1'b1;
            use_imm = 1'b1;
         end
         OP_HLT:  halt = 1'b1;
         default: halt = 1'b0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         d_valid <= 1'b0;
         d_wr    <= 1'b0;
         d_halt  <= 1'b0;
      end else begin
         d_valid <= in_valid;
         d_wr    <= wr;
         d_halt  <= halt;
      end
   end

   // Decoded fields, imm16 sign extended
   always_ff @(posedge clk) begin
      d_aluk    <= aluk;
      d_use_imm <= use_imm;
      d_dr      <= in_instr[DR_LSB +: REG_ID_W];
      d_sr1     <= in_instr[SR1_LSB +: REG_ID_W];
      d_sr2     <= in_instr[SR2_LSB +: REG_ID_W];
      d_imm     <= {{(WORD_W-IMM_W){in_instr[IMM_W-1]}}, in_instr[IMM_W-1:0]};
   end

   // Source must only send the defined opcodes
   a_defined_opcode: assert property (@(posedge clk) disable iff (!arst_n)
      instr_valid |-> instr[OPC_MSB -: OPC_W] inside {OP_NOP, OP_ADD, OP_SUB, OP_AND,
                                                      OP_OR, OP_XOR, OP_ADDI, OP_MOVI,
                                                      OP_HLT});

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file import pipe_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  reg_id_t ra1,
   input  reg_id_t ra2,
   output word_t   rd1,
   output word_t   rd2,
   input  logic    we,
   input  reg_id_t wa,
   input  word_t   wd
);

   word_t regs [NUM_GPR];

   // Single write port from writeback
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < NUM_GPR; i++) begin
            regs[i] <= '0;
         end
      end else if (we) begin
         regs[wa] <= wd;
      end
   end

   // Reads are combinational, the forwarding mux sits after them
   assign rd1 = regs[ra1];
   assign rd2 = regs[ra2];

   // A write to an unknown register would corrupt the whole file
   a_known_waddr: assert property (@(posedge clk) disable iff (!arst_n)
      we |-> !$isunknown(wa));

endmodule

`default_nettype wire

// ==== hw/operand_read.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_read import isa_pkg::*, pipe_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    d_valid,
   input  aluk_t   d_aluk,
   input  logic    d_wr,
   input  logic    d_halt,
   input  logic    d_use_imm,
   input  reg_id_t d_dr,
   input  reg_id_t d_sr1,
   input  reg_id_t d_sr2,
   input  word_t   d_imm,
   output reg_id_t rf_ra1,
   output reg_id_t rf_ra2,
   input  word_t   rf_rd1,
   input  word_t   rf_rd2,
   input  logic    ex_fwd_valid,
   input  reg_id_t ex_fwd_dr,
   input  word_t   ex_fwd_data,
   input  logic    wb_fwd_valid,
   input  reg_id_t wb_fwd_dr,
   input  word_t   wb_fwd_data,
   output logic    o_valid,
   output aluk_t   o_aluk,
   output logic    o_wr,
   output logic    o_halt,
   output reg_id_t o_dr,
   output word_t   o_a,
   output word_t   o_b
);

   word_t src_a;
   word_t src_b;

   // Youngest producer wins: execute, then the writeback latch, then the file
   function automatic word_t resolve(input reg_id_t sr, input word_t rf_val);
      if (ex_fwd_valid && ex_fwd_dr == sr) begin
         return ex_fwd_data;
      end else if (wb_fwd_valid && wb_fwd_dr == sr) begin
         return wb_fwd_data;
      end
      return rf_val;
   endfunction

   assign rf_ra1 = d_sr1;
   assign rf_ra2 = d_sr2;

   always_comb begin
      src_a = resolve(d_sr1, rf_rd1);
      src_b = d_use_imm ? d_imm : resolve(d_sr2, rf_rd2);
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         o_valid <= 1'b0;
         o_wr    <= 1'b0;
         o_halt  <= 1'b0;
      end else begin
         o_valid <= d_valid;
         o_wr    <= d_wr;
         o_halt  <= d_halt;
      end
   end

   always_ff @(posedge clk) begin
      o_aluk <= d_aluk;
      o_dr   <= d_dr;
      o_a    <= src_a;
      o_b    <= src_b;
   end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute import isa_pkg::*, pipe_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    o_valid,
   input  aluk_t   o_aluk,
   input  logic    o_wr,
   input  logic    o_halt,
   input  reg_id_t o_dr,
   input  word_t   o_a,
   input  word_t   o_b,
   output logic    ex_fwd_valid,
   output reg_id_t ex_fwd_dr,
   output word_t   ex_fwd_data,
   output logic    wb_fwd_valid,
   output reg_id_t wb_fwd_dr,
   output word_t   wb_fwd_data,
   output logic    x_valid,
   output logic    x_wr,
   output logic    x_halt,
   output reg_id_t x_dr,
   output word_t   x_data,
   output word_t   x_flags
);

   logic [WORD_W:0] wide;
   word_t           res;
   word_t           flags;
   logic            cf;
   logic            of;

   // Carry or borrow lands in the extra top bit
   always_comb begin
      wide = '0;
      res  = '0;
      cf   = 1'b0;
      of   = 1'b0;
      case (o_aluk)
         ALU_ADD: begin
            wide = {1'b0, o_a} + {1'b0, o_b};
            res  = wide[WORD_W-1:0];
            cf   = wide[WORD_W];
            of   = (o_a[WORD_W-1] == o_b[WORD_W-1]) && (res[WORD_W-1] != o_a[WORD_W-1]);
         end
         ALU_SUB: begin
            wide = {1'b0, o_a} - {1'b0, o_b};
            res  = wide[WORD_W-1:0];
            cf   = wide[WORD_W];
            of   = (o_a[WORD_W-1] != o_b[WORD_W-1]) && (res[WORD_W-1] != o_a[WORD_W-1]);
         end
         ALU_AND:   res = o_a & o_b;
         ALU_OR:    res = o_a | o_b;
         ALU_XOR:   res = o_a ^ o_b;
         ALU_PASSB: res = o_b;
         default:   res = o_b;
      endcase
   end

   always_comb begin
      flags          = '0;
      flags[FLAG_CF] = cf;
      flags[FLAG_ZF] = (res == '0);
      flags[FLAG_SF] = res[WORD_W-1];
      flags[FLAG_OF] = of;
   end

   // Result still in flight, one instruction ahead of operand read
   assign ex_fwd_valid = o_valid && o_wr;
   assign ex_fwd_dr    = o_dr;
   assign ex_fwd_data  = res;

   // Two ahead, sitting in the writeback latch
   assign wb_fwd_valid = x_valid && x_wr;
   assign wb_fwd_dr    = x_dr;
   assign wb_fwd_data  = x_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         x_valid <= 1'b0;
         x_wr    <= 1'b0;
         x_halt  <= 1'b0;
      end else begin
         x_valid <= o_valid;
         x_wr    <= o_wr;
         x_halt  <= o_halt;
      end
   end

   always_ff @(posedge clk) begin
      x_dr    <= o_dr;
      x_data  <= res;
      x_flags <= flags;
   end

endmodule

`default_nettype wire

// ==== hw/writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback import pipe_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    x_valid,
   input  logic    x_wr,
   input  logic    x_halt,
   input  reg_id_t x_dr,
   input  word_t   x_data,
   input  word_t   x_flags,
   output logic    rf_we,
   output reg_id_t rf_wa,
   output word_t   rf_wd,
   output logic    retire_valid,
   output logic    retire_wr,
   output reg_id_t retire_dr,
   output word_t   retire_data,
   output word_t   retire_flags,
   output logic    halted
);

   word_t eflags;

   // Nothing is written once halted
   assign rf_we = x_valid && x_wr && !halted;
   assign rf_wa = x_dr;
   assign rf_wd = x_data;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         eflags       <= '0;
         halted       <= 1'b0;
         retire_valid <= 1'b0;
         retire_wr    <= 1'b0;
      end else begin
         // Flags follow the register writes only
         if (rf_we) begin
            eflags <= x_flags;
         end
         if (x_valid && x_halt) begin
            halted <= 1'b1;
         end
         retire_valid <= x_valid && !halted;
         retire_wr    <= x_wr;
      end
   end

   always_ff @(posedge clk) begin
      retire_dr   <= x_dr;
      retire_data <= x_data;
   end

   // EFLAGS as seen after the retiring instruction
   assign retire_flags = eflags;

   // HLT itself retires, nothing after it does
   a_no_retire_halted: assert property (@(posedge clk) disable iff (!arst_n)
      $past(halted) |-> !retire_valid);

endmodule

`default_nettype wire

// ==== hw/pipeline.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline import isa_pkg::*, pipe_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    instr_valid,
   input  word_t   instr,
   output logic    retire_valid,
   output logic    retire_wr,
   output reg_id_t retire_dr,
   output word_t   retire_data,
   output word_t   retire_flags,
   output logic    halted
);

   // Decode to operand read
   logic    d_valid, d_wr, d_halt, d_use_imm;
   aluk_t   d_aluk;
   reg_id_t d_dr, d_sr1, d_sr2;
   word_t   d_imm;

   // Operand read to execute
   logic    o_valid, o_wr, o_halt;
   aluk_t   o_aluk;
   reg_id_t o_dr;
   word_t   o_a, o_b;

   // Execute to writeback
   logic    x_valid, x_wr, x_halt;
   reg_id_t x_dr;
   word_t   x_data, x_flags;

   // Forwarding paths back into operand read
   logic    ex_fwd_valid, wb_fwd_valid;
   reg_id_t ex_fwd_dr, wb_fwd_dr;
   word_t   ex_fwd_data, wb_fwd_data;

   // Register file ports
   reg_id_t rf_ra1, rf_ra2, rf_wa;
   word_t   rf_rd1, rf_rd2, rf_wd;
   logic    rf_we;

   decode_stage u_decode_stage (.*);

   operand_read u_operand_read (.*);

   register_file u_register_file (
      .clk    (clk),
      .arst_n (arst_n),
      .ra1    (rf_ra1),
      .ra2    (rf_ra2),
      .rd1    (rf_rd1),
      .rd2    (rf_rd2),
      .we     (rf_we),
      .wa     (rf_wa),
      .wd     (rf_wd)
   );

   execute u_execute (.*);

   writeback u_writeback (.*);

endmodule

`default_nettype wire

// ==== verification/pipeline_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipeline_tb import isa_pkg::*, pipe_pkg::*; ();

   localparam int DRAIN_TIMEOUT = 64;
   localparam int RANDOM_COUNT  = 150;

   logic    clk;
   logic    arst_n;
   logic    instr_valid;
   word_t   instr;
   logic    retire_valid;
   logic    retire_wr;
   reg_id_t retire_dr;
   word_t   retire_data;
   word_t   retire_flags;
   logic    halted;

   int cycle_cnt;
   int error_count;
   int check_count;
   int test_count;
   int test_start_errors;

   // Reference model state
   word_t model_regs [NUM_GPR];
   word_t model_flags;
   logic  model_halted;

   // Scoreboard of expected retirements, one entry per index across the queues
   logic    exp_wr_q [$];
   reg_id_t exp_dr_q [$];
   word_t   exp_data_q [$];
   word_t   exp_flags_q [$];
   logic    exp_halt_q [$];
   int      exp_cycle_q [$];

   opcode_t mix_ops [6] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI};

   pipeline DUT (
      .clk          (clk),
      .arst_n       (arst_n),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .retire_valid (retire_valid),
      .retire_wr    (retire_wr),
      .retire_dr    (retire_dr),
      .retire_data  (retire_data),
      .retire_flags (retire_flags),
      .halted       (halted)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycle_cnt = 0;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic check_word(input string name, input word_t got, input word_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s got=0x%08h exp=0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic check_reg_id(input string name, input reg_id_t got, input reg_id_t exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      check_count++;
      if (got !== exp) begin
         error_count++;
         $display("FAIL t=%0t %s got=%b exp=%b", $time, name, got, exp);
      end
   endtask

   function automatic word_t flag_word(input logic cf, input logic zf, input logic sf,
                                       input logic of);
      word_t f;
      f = '0;
      f[FLAG_CF] = cf;
      f[FLAG_ZF] = zf;
      f[FLAG_SF] = sf;
      f[FLAG_OF] = of;
      return f;
   endfunction

   // Retire outputs settle after the rising edge, sampled on the falling one
   always @(negedge clk) begin : retire_monitor
      logic    e_wr;
      reg_id_t e_dr;
      word_t   e_data;
      word_t   e_flags;
      logic    e_halt;
      int      e_cycle;
      if (arst_n && retire_valid) begin
         if (exp_wr_q.size() == 0) begin
            error_count++;
            $display("t=%0t an instruction retired that was never expected to", $time);
         end else begin
            e_wr    = exp_wr_q.pop_front();
            e_dr    = exp_dr_q.pop_front();
            e_data  = exp_data_q.pop_front();
            e_flags = exp_flags_q.pop_front();
            e_halt  = exp_halt_q.pop_front();
            e_cycle = exp_cycle_q.pop_front();
            check_bit("retire_wr", retire_wr, e_wr);
            if (e_wr) begin
               check_reg_id("retire_dr", retire_dr, e_dr);
               check_word("retire_data", retire_data, e_data);
            end
            check_word("retire_flags", retire_flags, e_flags);
            check_bit("halted", halted, e_halt);
            check_word("retire latency", word_t'(cycle_cnt - e_cycle), word_t'(PIPE_LATENCY));
         end
      end
   end

   // Drives one instruction and predicts its retirement
   task automatic issue(input opcode_t opc, input reg_id_t dr, input reg_id_t sr1,
                        input reg_id_t sr2, input logic [15:0] imm16);
      word_t  a;
      word_t  b;
      word_t  res;
      logic   cf;
      logic   of;
      logic   wr;
      longint ua;
      longint sa;
      int     sample_cycle;
      logic   push;
      @(negedge clk);
      instr = '0;
      instr[OPC_MSB -: OPC_W]     = opc;
      instr[DR_LSB +: REG_ID_W]   = dr;
      instr[SR1_LSB +: REG_ID_W]  = sr1;
      instr[SR2_LSB +: REG_ID_W]  = sr2;
      instr[IMM_W-1:0]            = imm16;
      instr_valid  = 1'b1;
      sample_cycle = cycle_cnt + 1;
      a   = model_regs[sr1];
      b   = (opc == OP_ADDI || opc == OP_MOVI) ? {{16{imm16[15]}}, imm16} : model_regs[sr2];
      res = '0;
      cf  = 1'b0;
      of  = 1'b0;
      wr  = 1'b1;
      case (opc)
         OP_ADD, OP_ADDI: begin
            ua  = longint'(a) + longint'(b);
            sa  = longint'($signed(a)) + longint'($signed(b));
            res = ua[31:0];
            cf  = ua[32];
            of  = (sa != longint'($signed(res)));
         end
         OP_SUB: begin
            sa  = longint'($signed(a)) - longint'($signed(b));
            res = a - b;
            cf  = (a < b);
            of  = (sa != longint'($signed(res)));
         end
         OP_AND:  res = a & b;
         OP_OR:   res = a | b;
         OP_XOR:  res = a ^ b;
         OP_MOVI: res = b;
         default: wr = 1'b0;
      endcase
      push = !model_halted;
      if (push && wr) begin
         model_regs[dr] = res;
         model_flags    = flag_word(cf, res == '0, res[31], of);
      end
      @(posedge clk);
      if (push) begin
         exp_wr_q.push_back(wr);
         exp_dr_q.push_back(dr);
         exp_data_q.push_back(res);
         exp_flags_q.push_back(model_flags);
         exp_halt_q.push_back(opc == OP_HLT);
         exp_cycle_q.push_back(sample_cycle);
         if (opc == OP_HLT) begin
            model_halted = 1'b1;
         end
      end
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(negedge clk);
         instr_valid = 1'b0;
      end
   endtask

   task automatic wait_drain();
      int waited;
      idle(1);
      waited = 0;
      while (exp_wr_q.size() != 0 && waited < DRAIN_TIMEOUT) begin
         @(posedge clk);
         waited++;
      end
      if (exp_wr_q.size() != 0) begin
         $display("timeout with %0d retirements still outstanding", exp_wr_q.size());
         $display("*** FAILED ***");
         $finish;
      end
      @(negedge clk);
   endtask

   task automatic report_test(input string name);
      test_count++;
      $display("test %s: %0d errors", name, error_count - test_start_errors);
      test_start_errors = error_count;
   endtask

   task automatic test_reset_movi();
      @(negedge clk);
      check_bit("retire_valid", retire_valid, 1'b0);
      check_bit("halted", halted, 1'b0);
      issue(OP_MOVI, 3'd1, 3'd0, 3'd0, 16'h1234);
      issue(OP_MOVI, 3'd2, 3'd0, 3'd0, 16'h8001);
      wait_drain();
   endtask

   // Isolated instructions and a short burst
   task automatic test_latency();
      for (int i = 0; i < 6; i++) begin
         issue(OP_ADDI, reg_id_t'(i), reg_id_t'(i + 1), 3'd0, 16'(i * 3 + 1));
         idle(i + 1);
      end
      issue(OP_MOVI, 3'd4, 3'd0, 3'd0, 16'h0042);
      issue(OP_NOP, 3'd0, 3'd0, 3'd0, 16'h0000);
      issue(OP_OR, 3'd5, 3'd4, 3'd1, 16'h0000);
      issue(OP_SUB, 3'd6, 3'd5, 3'd4, 16'h0000);
      wait_drain();
   endtask

   task automatic test_forward_chains();
      issue(OP_MOVI, 3'd1, 3'd0, 3'd0, 16'h0003);
      issue(OP_MOVI, 3'd2, 3'd0, 3'd0, 16'h0009);
      issue(OP_MOVI, 3'd3, 3'd0, 3'd0, 16'hfffe);
      // Sources three back come from the file
      issue(OP_ADD, 3'd4, 3'd1, 3'd1, 16'h0000);
      issue(OP_SUB, 3'd5, 3'd2, 3'd4, 16'h0000);
      issue(OP_OR, 3'd6, 3'd3, 3'd4, 16'h0000);
      issue(OP_AND, 3'd7, 3'd5, 3'd6, 16'h0000);
      issue(OP_ADDI, 3'd7, 3'd7, 3'd0, 16'h0010);
      issue(OP_XOR, 3'd0, 3'd7, 3'd5, 16'h0000);
      // Two writers in flight, the younger must win
      issue(OP_MOVI, 3'd1, 3'd0, 3'd0, 16'h0001);
      issue(OP_MOVI, 3'd1, 3'd0, 3'd0, 16'h0002);
      issue(OP_ADD, 3'd2, 3'd1, 3'd1, 16'h0000);
      wait_drain();
   endtask

   task automatic test_random_mix();
      for (int i = 0; i < NUM_GPR; i++) begin
         issue(OP_MOVI, reg_id_t'(i), 3'd0, 3'd0, 16'($urandom));
      end
      for (int n = 0; n < RANDOM_COUNT; n++) begin
         issue(mix_ops[$urandom_range(0, 5)], reg_id_t'($urandom_range(0, 7)),
               reg_id_t'($urandom_range(0, 7)), reg_id_t'($urandom_range(0, 7)),
               16'($urandom));
         if ($urandom_range(0, 3) == 0) begin
            idle($urandom_range(1, 3));
         end
      end
      wait_drain();
   endtask

   task automatic test_flags();
      issue(OP_MOVI, 3'd1, 3'd0, 3'd0, 16'h1234);
      issue(OP_MOVI, 3'd2, 3'd0, 3'd0, 16'h1234);
      issue(OP_SUB, 3'd3, 3'd1, 3'd2, 16'h0000);
      wait_drain();
      check_word("retire_flags", retire_flags, flag_word(1'b0, 1'b1, 1'b0, 1'b0));
      // 0xFFFF8000 doubled sixteen times gives 0x80000000
      issue(OP_MOVI, 3'd4, 3'd0, 3'd0, 16'hffff);
      issue(OP_MOVI, 3'd5, 3'd0, 3'd0, 16'h0001);
      issue(OP_MOVI, 3'd7, 3'd0, 3'd0, 16'h8000);
      repeat (16) issue(OP_ADD, 3'd7, 3'd7, 3'd7, 16'h0000);
      issue(OP_XOR, 3'd6, 3'd7, 3'd4, 16'h0000);
      issue(OP_ADD, 3'd3, 3'd6, 3'd5, 16'h0000);
      wait_drain();
      check_word("retire_data", retire_data, 32'h8000_0000);
      check_word("retire_flags", retire_flags, flag_word(1'b0, 1'b0, 1'b1, 1'b1));
      issue(OP_ADD, 3'd3, 3'd4, 3'd5, 16'h0000);
      wait_drain();
      check_word("retire_flags", retire_flags, flag_word(1'b1, 1'b1, 1'b0, 1'b0));
   endtask

   task automatic test_halt();
      issue(OP_MOVI, 3'd1, 3'd0, 3'd0, 16'h002a);
      issue(OP_HLT, 3'd0, 3'd0, 3'd0, 16'h0000);
      issue(OP_MOVI, 3'd2, 3'd0, 3'd0, 16'h0063);
      issue(OP_ADD, 3'd3, 3'd1, 3'd1, 16'h0000);
      wait_drain();
      // Window in which the trailing instructions would have retired
      repeat (PIPE_LATENCY + 2) begin
         check_bit("retire_valid", retire_valid, 1'b0);
         check_bit("halted", halted, 1'b1);
         @(negedge clk);
      end
   endtask

   initial begin
      arst_n            = 1'b0;
      instr_valid       = 1'b0;
      instr             = '0;
      error_count       = 0;
      check_count       = 0;
      test_count        = 0;
      test_start_errors = 0;
      model_flags       = '0;
      model_halted      = 1'b0;
      for (int i = 0; i < NUM_GPR; i++) begin
         model_regs[i] = '0;
      end
      void'($urandom(93690));
      repeat (16) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      test_reset_movi();
      report_test("reset_movi");
      test_latency();
      report_test("latency");
      test_forward_chains();
      report_test("forward_chains");
      test_random_mix();
      report_test("random_mix");
      test_flags();
      report_test("flags");
      test_halt();
      report_test("halt");

      $display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count,
               error_count);
      if (error_count == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== filelist.f ====
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/decode_stage.sv
hw/register_file.sv
hw/operand_read.sv
hw/execute.sv
hw/writeback.sv
hw/pipeline.sv
verification/pipeline_tb.sv
